//--- hw/pe_array_ctrl.sv
module pe_array_ctrl import pe_array_pkg::*; #(
    parameter int PE_ROW = 2,
    parameter int PE_COL = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_vld_i,
    output logic                     cfg_rdy_o,
    input  aram_addr_t               cfg_aram_base_i,
    input  wram_addr_t               cfg_wram_base_i,
    input  ich_t                     cfg_ich_i,
    input  len_t                     cfg_len_i,
    input  tap_t                     cfg_wei_i,
    input  dila_t                    cfg_dila_i,
    input  logic [PE_ROW*PE_COL-1:0] out_vld_i,
    input  logic [PE_ROW*PE_COL-1:0] out_lst_i,
    output logic                     is_idle_o,
    output logic                     start_o,
    output aram_addr_t               aram_base_o,
    output wram_addr_t               wram_base_o,
    output ich_t                     ich_o,
    output len_t                     len_o,
    output tap_t                     wei_o,
    output dila_t                    dila_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic                     cfg_xfer;
    logic [PE_ROW*PE_COL-1:0] done_q;

    assign cfg_rdy_o = (state_q == CTRL_IDLE);
    assign is_idle_o = (state_q == CTRL_IDLE);
    assign cfg_xfer  = cfg_vld_i && cfg_rdy_o;

    // ===================================================================
    // Layer settings
    // ===================================================================
    always_ff @(posedge clk) begin
        if (cfg_xfer) begin
            aram_base_o <= cfg_aram_base_i;
            wram_base_o <= cfg_wram_base_i;
            ich_o       <= cfg_ich_i;
            len_o       <= cfg_len_i;
            wei_o       <= cfg_wei_i;
            dila_o      <= cfg_dila_i;
        end
    end

    // Start pulse lines up with the load state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_o <= 1'b0;
        end else begin
            start_o <= cfg_xfer;
        end
    end

    // ===================================================================
    // Completion flags, one per PE
    // ===================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= '1;
        end else if (cfg_xfer) begin
            done_q <= '0;
        end else begin
            done_q <= done_q | (out_vld_i & out_lst_i);
        end
    end

    // ===================================================================
    // FSM
    // ===================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (cfg_xfer) begin
                    state_d = CTRL_LOAD;
                end
            end
            CTRL_LOAD: begin
                state_d = CTRL_CONV;
            end
            CTRL_CONV: begin
                if (&done_q) begin
                    state_d = CTRL_IDLE;
                end
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- hw/pe_array_pkg.sv
package pe_array_pkg;

    // ===================================================================
    // Data widths
    // ===================================================================

    // Activation and weight samples are signed
    typedef logic signed [7:0]  act_t;
    typedef logic signed [7:0]  wei_t;
    typedef logic signed [23:0] psum_t;

    // ===================================================================
    // Addresses and layer settings
    // ===================================================================
    typedef logic [11:0] aram_addr_t;
    typedef logic [12:0] wram_addr_t;
    typedef logic [7:0]  oram_addr_t;

    // Counts are stored minus one
    typedef logic [7:0]  ich_t;
    typedef logic [9:0]  len_t;
    typedef logic [2:0]  tap_t;

    // Tap spacing is 1 << dila
    typedef logic [1:0]  dila_t;

    // One activation RAM line of 256 words per input channel
    localparam int ACT_LINE_W = 8;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOAD,
        CTRL_CONV
    } ctrl_state_t;

endpackage

//--- hw/pe_array_top.sv
module pe_array_top import pe_array_pkg::*; #(
    parameter int PE_ROW = 2,
    parameter int PE_COL = 2
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cfg_vld_i,
    output logic                                cfg_rdy_o,
    input  aram_addr_t                          cfg_aram_base_i,
    input  wram_addr_t                          cfg_wram_base_i,
    input  ich_t                                cfg_ich_i,
    input  len_t                                cfg_len_i,
    input  tap_t                                cfg_wei_i,
    input  dila_t                               cfg_dila_i,
    output logic                                is_idle_o,
    output logic       [PE_COL-1:0]             aram_req_o,
    output aram_addr_t [PE_COL-1:0]             aram_addr_o,
    input  act_t       [PE_COL-1:0]             aram_rdata_i,
    output logic       [PE_ROW-1:0][PE_COL-1:0] wram_req_o,
    output wram_addr_t [PE_ROW-1:0][PE_COL-1:0] wram_addr_o,
    input  wei_t       [PE_ROW-1:0][PE_COL-1:0] wram_rdata_i,
    output logic       [PE_ROW-1:0][PE_COL-1:0] oram_vld_o,
    output logic       [PE_ROW-1:0][PE_COL-1:0] oram_lst_o,
    output oram_addr_t [PE_ROW-1:0][PE_COL-1:0] oram_idx_o,
    output psum_t      [PE_ROW-1:0][PE_COL-1:0] oram_dat_o
);

    logic       start;
    aram_addr_t aram_base;
    wram_addr_t wram_base;
    ich_t       ich;
    len_t       len;
    tap_t       wei;
    dila_t      dila;

    // Weight requests as the generators produce them, column first
    logic       [PE_COL-1:0][PE_ROW-1:0] gen_wram_req;
    wram_addr_t [PE_COL-1:0][PE_ROW-1:0] gen_wram_addr;

    logic       [PE_COL-1:0]       col_mac_vld;
    logic       [PE_COL-1:0]       col_mac_first;
    logic       [PE_COL-1:0][1:0]  col_mac_last;
    oram_addr_t [PE_COL-1:0]       col_mac_idx;

    pe_array_ctrl #(
        .PE_ROW (PE_ROW),
        .PE_COL (PE_COL)
    ) i_pe_array_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld_i       (cfg_vld_i),
        .cfg_rdy_o       (cfg_rdy_o),
        .cfg_aram_base_i (cfg_aram_base_i),
        .cfg_wram_base_i (cfg_wram_base_i),
        .cfg_ich_i       (cfg_ich_i),
        .cfg_len_i       (cfg_len_i),
        .cfg_wei_i       (cfg_wei_i),
        .cfg_dila_i      (cfg_dila_i),
        .out_vld_i       (oram_vld_o),
        .out_lst_i       (oram_lst_o),
        .is_idle_o       (is_idle_o),
        .start_o         (start),
        .aram_base_o     (aram_base),
        .wram_base_o     (wram_base),
        .ich_o           (ich),
        .len_o           (len),
        .wei_o           (wei),
        .dila_o          (dila)
    );

    // ===================================================================
    // Address generator columns
    // ===================================================================
    for (genvar c = 0; c < PE_COL; c++) begin : g_col
        pe_col_gen #(
            .PE_ROW  (PE_ROW),
            .PE_COL  (PE_COL),
            .COL_IDX (c)
        ) i_pe_col_gen (
            .clk         (clk),
            .rst_n       (rst_n),
            .start_i     (start),
            .aram_base_i (aram_base),
            .wram_base_i (wram_base),
            .ich_i       (ich),
            .len_i       (len),
            .wei_i       (wei),
            .dila_i      (dila),
            .aram_req_o  (aram_req_o[c]),
            .aram_addr_o (aram_addr_o[c]),
            .wram_req_o  (gen_wram_req[c]),
            .wram_addr_o (gen_wram_addr[c]),
            .mac_vld_o   (col_mac_vld[c]),
            .mac_first_o (col_mac_first[c]),
            .mac_last_o  (col_mac_last[c]),
            .mac_idx_o   (col_mac_idx[c])
        );
    end

    // ===================================================================
    // PE grid and weight port transposition
    // ===================================================================
    for (genvar r = 0; r < PE_ROW; r++) begin : g_pe_row
        for (genvar c = 0; c < PE_COL; c++) begin : g_pe_col
            assign wram_req_o[r][c]  = gen_wram_req[c][r];
            assign wram_addr_o[r][c] = gen_wram_addr[c][r];

            pe_mac i_pe_mac (
                .clk         (clk),
                .rst_n       (rst_n),
                .mac_vld_i   (col_mac_vld[c]),
                .mac_first_i (col_mac_first[c]),
                .mac_last_i  (col_mac_last[c]),
                .mac_idx_i   (col_mac_idx[c]),
                .act_i       (aram_rdata_i[c]),
                .wei_i       (wram_rdata_i[r][c]),
                .out_vld_o   (oram_vld_o[r][c]),
                .out_lst_o   (oram_lst_o[r][c]),
                .out_idx_o   (oram_idx_o[r][c]),
                .out_dat_o   (oram_dat_o[r][c])
            );
        end
    end

endmodule

//--- hw/pe_col_gen.sv
module pe_col_gen import pe_array_pkg::*; #(
    parameter int PE_ROW  = 2,
    parameter int PE_COL  = 2,
    parameter int COL_IDX = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  aram_addr_t              aram_base_i,
    input  wram_addr_t              wram_base_i,
    input  ich_t                    ich_i,
    input  len_t                    len_i,
    input  tap_t                    wei_i,
    input  dila_t                   dila_i,
    output logic                    aram_req_o,
    output aram_addr_t              aram_addr_o,
    output logic [PE_ROW-1:0]       wram_req_o,
    output wram_addr_t [PE_ROW-1:0] wram_addr_o,
    output logic                    mac_vld_o,
    output logic                    mac_first_o,
    output logic [1:0]              mac_last_o,
    output oram_addr_t              mac_idx_o
);

    localparam int COL_SH = $clog2(PE_COL);

    logic       run_q;
    oram_addr_t grp_q;
    ich_t       ch_q;
    tap_t       tap_q;
    wram_addr_t wch_off_q;

    oram_addr_t grp_last_q;
    wram_addr_t row_stride_q;

    logic [10:0] len_plus;
    wram_addr_t  ch_stride;
    wram_addr_t  ich_plus;
    aram_addr_t  pos;
    logic        tap_end;
    logic        ch_end;
    logic        grp_end;

    assign len_plus  = {1'b0, len_i} + 11'd1;
    assign ch_stride = wram_addr_t'(wei_i) + 13'd1;
    assign ich_plus  = wram_addr_t'(ich_i) + 13'd1;

    assign tap_end = (tap_q == wei_i);
    assign ch_end  = (ch_q == ich_i);
    assign grp_end = (grp_q == grp_last_q);

    // Per-run constants, taken while the start pulse is high
    always_ff @(posedge clk) begin
        if (start_i) begin
            grp_last_q   <= oram_addr_t'((len_plus >> COL_SH) - 11'd1);
            row_stride_q <= ich_plus * ch_stride;
        end
    end

    // ===================================================================
    // Group, channel and tap counters
    // ===================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q     <= 1'b0;
            grp_q     <= '0;
            ch_q      <= '0;
            tap_q     <= '0;
            wch_off_q <= '0;
        end else if (start_i) begin
            run_q     <= 1'b1;
            grp_q     <= '0;
            ch_q      <= '0;
            tap_q     <= '0;
            wch_off_q <= '0;
        end else if (run_q) begin
            if (tap_end) begin
                tap_q <= '0;
                if (ch_end) begin
                    ch_q      <= '0;
                    wch_off_q <= '0;
                    if (grp_end) begin
                        run_q <= 1'b0;
                    end else begin
                        grp_q <= grp_q + 8'd1;
                    end
                end else begin
                    ch_q      <= ch_q + 8'd1;
                    wch_off_q <= wch_off_q + ch_stride;
                end
            end else begin
                tap_q <= tap_q + 3'd1;
            end
        end
    end

    // ===================================================================
    // RAM requests
    // ===================================================================
    assign pos = (aram_addr_t'(grp_q) << COL_SH) + aram_addr_t'(COL_IDX);

    assign aram_req_o  = run_q;
    assign aram_addr_o = aram_base_i + (aram_addr_t'(ch_q) << ACT_LINE_W) + pos
                       + (aram_addr_t'(tap_q) << dila_i);

    for (genvar r = 0; r < PE_ROW; r++) begin : g_row
        assign wram_req_o[r]  = run_q;
        assign wram_addr_o[r] = wram_base_i + wram_addr_t'(r) * row_stride_q
                              + wch_off_q + wram_addr_t'(tap_q);
    end

    // ===================================================================
    // MAC control, one cycle behind the request
    // ===================================================================

    // mac_last_o[0] ends a group, mac_last_o[1] also marks the final group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac_vld_o   <= 1'b0;
            mac_first_o <= 1'b0;
            mac_last_o  <= 2'b00;
        end else begin
            mac_vld_o     <= run_q;
            mac_first_o   <= run_q && (tap_q == '0) && (ch_q == '0);
            mac_last_o[0] <= run_q && tap_end && ch_end;
            mac_last_o[1] <= run_q && tap_end && ch_end && grp_end;
        end
    end

    always_ff @(posedge clk) begin
        mac_idx_o <= grp_q;
    end

endmodule

//--- hw/pe_mac.sv
module pe_mac import pe_array_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mac_vld_i,
    input  logic       mac_first_i,
    input  logic [1:0] mac_last_i,
    input  oram_addr_t mac_idx_i,
    input  act_t       act_i,
    input  wei_t       wei_i,
    output logic       out_vld_o,
    output logic       out_lst_o,
    output oram_addr_t out_idx_o,
    output psum_t      out_dat_o
);

    psum_t prod;
    psum_t acc_q;
    psum_t sum_nxt;
    logic  grp_done;

    // Signed product at full accumulator width
    assign prod     = act_i * wei_i;
    assign sum_nxt  = mac_first_i ? prod : acc_q + prod;
    assign grp_done = mac_vld_i && mac_last_i[0];

    always_ff @(posedge clk) begin
        if (mac_vld_i) begin
            acc_q <= sum_nxt;
        end
    end

    // Result of a finished group
    always_ff @(posedge clk) begin
        if (grp_done) begin
            out_dat_o <= sum_nxt;
            out_idx_o <= mac_idx_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld_o <= 1'b0;
            out_lst_o <= 1'b0;
        end else begin
            out_vld_o <= grp_done;
            out_lst_o <= grp_done && mac_last_i[1];
        end
    end

endmodule

//--- pe_array.f
hw/pe_array_pkg.sv
hw/pe_array_ctrl.sv
hw/pe_col_gen.sv
hw/pe_mac.sv
hw/pe_array_top.sv
sim/pe_array_asserts.sv
sim/pe_array_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the PE array testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pe_array_tb \
    -f pe_array.f \
    -o pe_array_sim

./obj_dir/pe_array_sim

//--- sim/pe_array_asserts.sv
module pe_array_asserts #(
    parameter int PE_ROW = 2,
    parameter int PE_COL = 2
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     cfg_vld_i,
    input logic                     cfg_rdy_i,
    input logic                     is_idle_i,
    input logic [PE_COL-1:0]        aram_req_i,
    input logic [PE_ROW*PE_COL-1:0] wram_req_i,
    input logic [PE_ROW*PE_COL-1:0] oram_vld_i,
    input logic [PE_ROW*PE_COL-1:0] oram_lst_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // ===================================================================
    // Protocol rules of the array
    // ===================================================================
    no_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        is_idle_i |-> (aram_req_i == '0) && (wram_req_i == '0))
        else $error("Request strobe while the array is idle");

    // Last flag only travels with a valid output
    lst_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
        (oram_lst_i & ~oram_vld_i) == '0)
        else $error("oram_lst_o high without oram_vld_o");

    // A transfer takes the array out of idle on the next cycle
    xfer_leaves_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_vld_i && cfg_rdy_i |=> !cfg_rdy_i && !is_idle_i)
        else $error("Array still ready after a configuration transfer");

endmodule

//--- sim/pe_array_tb.sv
module pe_array_tb import pe_array_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PE_ROW      = 2;
    localparam int PE_COL      = 2;
    localparam int NUM_CFG     = 5;
    localparam int ARAM_DEPTH  = 4096;
    localparam int WRAM_DEPTH  = 8192;
    localparam int RDY_TIMEOUT = 100;
    localparam int RUN_TIMEOUT = 5000;
    localparam logic [31:0] LFSR_SEED = 32'h6516e936;
    localparam logic [31:0] LFSR_POLY = 32'hB4BCD35C;

    logic       clk;
    logic       rst_n;
    logic       cfg_vld;
    logic       cfg_rdy;
    aram_addr_t cfg_aram_base;
    wram_addr_t cfg_wram_base;
    ich_t       cfg_ich;
    len_t       cfg_len;
    tap_t       cfg_wei;
    dila_t      cfg_dila;
    logic       is_idle;

    logic       [PE_COL-1:0]             aram_req;
    aram_addr_t [PE_COL-1:0]             aram_addr;
    act_t       [PE_COL-1:0]             aram_rdata = '0;
    logic       [PE_ROW-1:0][PE_COL-1:0] wram_req;
    wram_addr_t [PE_ROW-1:0][PE_COL-1:0] wram_addr;
    wei_t       [PE_ROW-1:0][PE_COL-1:0] wram_rdata = '0;
    logic       [PE_ROW-1:0][PE_COL-1:0] oram_vld;
    logic       [PE_ROW-1:0][PE_COL-1:0] oram_lst;
    oram_addr_t [PE_ROW-1:0][PE_COL-1:0] oram_idx;
    psum_t      [PE_ROW-1:0][PE_COL-1:0] oram_dat;

    // RAM contents and the requests waiting for their answer
    act_t                                amem [ARAM_DEPTH];
    wei_t                                wmem [WRAM_DEPTH];
    logic       [PE_COL-1:0]             aram_req_q = '0;
    aram_addr_t [PE_COL-1:0]             aram_addr_q = '0;
    logic       [PE_ROW-1:0][PE_COL-1:0] wram_req_q = '0;
    wram_addr_t [PE_ROW-1:0][PE_COL-1:0] wram_addr_q = '0;

    logic [31:0] lfsr_q;
    int          err_cnt = 0;

    // ===================================================================
    // Configuration table, expected group count in the last column
    // ===================================================================
    aram_addr_t tbl_abase [NUM_CFG] = '{12'h010, 12'h020, 12'h040, 12'h100, 12'h300};
    wram_addr_t tbl_wbase [NUM_CFG] = '{13'h0000, 13'h0100, 13'h0200, 13'h0400, 13'h0800};
    ich_t       tbl_ich   [NUM_CFG] = '{8'd2, 8'd1, 8'd3, 8'd1, 8'd0};
    len_t       tbl_len   [NUM_CFG] = '{10'd7, 10'd5, 10'd9, 10'd3, 10'd11};
    tap_t       tbl_wei   [NUM_CFG] = '{3'd2, 3'd3, 3'd4, 3'd7, 3'd0};
    dila_t      tbl_dila  [NUM_CFG] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0};
    int         tbl_ngrp  [NUM_CFG] = '{4, 3, 5, 2, 6};

    pe_array_top #(
        .PE_ROW (PE_ROW),
        .PE_COL (PE_COL)
    ) i_pe_array_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld_i       (cfg_vld),
        .cfg_rdy_o       (cfg_rdy),
        .cfg_aram_base_i (cfg_aram_base),
        .cfg_wram_base_i (cfg_wram_base),
        .cfg_ich_i       (cfg_ich),
        .cfg_len_i       (cfg_len),
        .cfg_wei_i       (cfg_wei),
        .cfg_dila_i      (cfg_dila),
        .is_idle_o       (is_idle),
        .aram_req_o      (aram_req),
        .aram_addr_o     (aram_addr),
        .aram_rdata_i    (aram_rdata),
        .wram_req_o      (wram_req),
        .wram_addr_o     (wram_addr),
        .wram_rdata_i    (wram_rdata),
        .oram_vld_o      (oram_vld),
        .oram_lst_o      (oram_lst),
        .oram_idx_o      (oram_idx),
        .oram_dat_o      (oram_dat)
    );

    bind pe_array_top pe_array_asserts #(
        .PE_ROW (PE_ROW),
        .PE_COL (PE_COL)
    ) i_pe_array_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_vld_i  (cfg_vld_i),
        .cfg_rdy_i  (cfg_rdy_o),
        .is_idle_i  (is_idle_o),
        .aram_req_i (aram_req_o),
        .wram_req_i (wram_req_o),
        .oram_vld_i (oram_vld_o),
        .oram_lst_i (oram_lst_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Synchronous RAMs, data of a request shows up one cycle later
    always @(negedge clk) begin
        for (int c = 0; c < PE_COL; c++) begin
            if (aram_req_q[c]) begin
                aram_rdata[c] = amem[aram_addr_q[c]];
            end
            for (int r = 0; r < PE_ROW; r++) begin
                if (wram_req_q[r][c]) begin
                    wram_rdata[r][c] = wmem[wram_addr_q[r][c]];
                end
            end
        end
        aram_req_q  = aram_req;
        aram_addr_q = aram_addr;
        wram_req_q  = wram_req;
        wram_addr_q = wram_addr;
    end

    // ===================================================================
    // Random fill and reference model
    // ===================================================================
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
        return b;
    endfunction

    task automatic fill_rams();
        lfsr_q = LFSR_SEED;
        for (int a = 0; a < ARAM_DEPTH; a++) begin
            amem[a] = act_t'(rand_byte());
        end
        for (int a = 0; a < WRAM_DEPTH; a++) begin
            wmem[a] = wei_t'(rand_byte());
        end
    endtask

    // Sum over channels and taps for row r, column c, group g
    function automatic psum_t ref_sum(int n, int r, int c, int g);
        int acc;
        int n_tap;
        int a_addr;
        int w_addr;
        acc   = 0;
        n_tap = int'(tbl_wei[n]) + 1;
        for (int ch = 0; ch <= int'(tbl_ich[n]); ch++) begin
            for (int k = 0; k < n_tap; k++) begin
                a_addr = int'(tbl_abase[n]) + (ch << ACT_LINE_W) + g * PE_COL + c
                       + (k << tbl_dila[n]);
                w_addr = int'(tbl_wbase[n]) + r * (int'(tbl_ich[n]) + 1) * n_tap
                       + ch * n_tap + k;
                acc += int'(amem[a_addr % ARAM_DEPTH]) * int'(wmem[w_addr % WRAM_DEPTH]);
            end
        end
        return psum_t'(acc);
    endfunction

    // ===================================================================
    // Compare tasks
    // ===================================================================
    task automatic check_psum(string name, psum_t got, psum_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic check_idx(string name, oram_addr_t got, oram_addr_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic abort_run(string why);
        err_cnt++;
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    // ===================================================================
    // Configuration and run
    // ===================================================================
    task automatic wait_ready();
        int cyc;
        cyc = 0;
        while (!cfg_rdy) begin
            cyc++;
            if (cyc > RDY_TIMEOUT) begin
                abort_run("Timeout waiting for cfg_rdy_o");
            end
            @(negedge clk);
        end
    endtask

    // Checks every output strobe of a run against the reference model
    task automatic run_config(int n);
        int seen [PE_ROW][PE_COL];
        int last;
        int cyc;
        logic done;
        last = tbl_ngrp[n] - 1;
        for (int r = 0; r < PE_ROW; r++) begin
            for (int c = 0; c < PE_COL; c++) begin
                seen[r][c] = 0;
            end
        end
        wait_ready();
        cfg_aram_base = tbl_abase[n];
        cfg_wram_base = tbl_wbase[n];
        cfg_ich       = tbl_ich[n];
        cfg_len       = tbl_len[n];
        cfg_wei       = tbl_wei[n];
        cfg_dila      = tbl_dila[n];
        cfg_vld       = 1'b1;
        @(negedge clk);
        cfg_vld = 1'b0;
        check_bit("cfg_rdy_o", cfg_rdy, 1'b0);
        check_bit("is_idle_o", is_idle, 1'b0);

        done = 1'b0;
        cyc  = 0;
        while (!done) begin
            for (int r = 0; r < PE_ROW; r++) begin
                for (int c = 0; c < PE_COL; c++) begin
                    if (oram_vld[r][c]) begin
                        if (seen[r][c] > last) begin
                            abort_run($sformatf("PE %0d/%0d sent too many outputs", r, c));
                        end
                        check_idx($sformatf("oram_idx_o[%0d][%0d]", r, c), oram_idx[r][c],
                                  oram_addr_t'(seen[r][c]));
                        check_psum($sformatf("oram_dat_o[%0d][%0d]", r, c), oram_dat[r][c],
                                   ref_sum(n, r, c, seen[r][c]));
                        check_bit($sformatf("oram_lst_o[%0d][%0d]", r, c), oram_lst[r][c],
                                  seen[r][c] == last);
                        seen[r][c]++;
                    end
                end
            end
            if (is_idle) begin
                done = 1'b1;
            end else begin
                check_bit("cfg_rdy_o", cfg_rdy, 1'b0);
                cyc++;
                if (cyc > RUN_TIMEOUT) begin
                    abort_run("Timeout waiting for the array to return to idle");
                end
                @(negedge clk);
            end
        end

        for (int r = 0; r < PE_ROW; r++) begin
            for (int c = 0; c < PE_COL; c++) begin
                if (seen[r][c] != tbl_ngrp[n]) begin
                    abort_run($sformatf("PE %0d/%0d sent %0d outputs instead of %0d",
                                        r, c, seen[r][c], tbl_ngrp[n]));
                end
            end
        end
        check_bit("cfg_rdy_o", cfg_rdy, 1'b1);
    endtask

    initial begin
        rst_n         = 1'b0;
        cfg_vld       = 1'b0;
        cfg_aram_base = '0;
        cfg_wram_base = '0;
        cfg_ich       = '0;
        cfg_len       = '0;
        cfg_wei       = '0;
        cfg_dila      = '0;
        fill_rams();

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_bit("cfg_rdy_o", cfg_rdy, 1'b1);
        check_bit("is_idle_o", is_idle, 1'b1);

        for (int n = 0; n < NUM_CFG; n++) begin
            run_config(n);
            @(negedge clk);
        end

        if (err_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "%0d checks failed", err_cnt);
        end
    end

endmodule
